// File: hdl/pulse_seq_pkg.sv
package pulse_seq_pkg;

   localparam int NUM_CHANNELS   = 2;  // Pulse channels in the generate loop
   localparam int CFG_CREDITS    = 4;  // Receiver buffer depth and host starting credits
   localparam int CFG_PTR_W      = $clog2(CFG_CREDITS);
   localparam int ATT_STEP       = 6;  // Extra attenuation for first pulses and guard
   localparam int ATT_GUARD      = 20; // Guard length before the period end
   localparam int INHIBIT_LEAD   = 5;  // Blocking closes this early before nutation
   localparam int CW_SYNC_CYCLES = 16; // Scope trigger length in CW mode

   // Configuration word addresses
   localparam int ADDR_PERIOD      = 0;
   localparam int ADDR_CH0_BASE    = 1;  // p1_start, p1_stop, p2_start, p2_stop per channel
   localparam int ADDR_NUT_W       = 9;
   localparam int ADDR_NUT_D       = 10;
   localparam int ADDR_ATT         = 11;
   localparam int ADDR_BLOCK_DELAY = 12;
   localparam int ADDR_MODE        = 13; // Bit 0 cw, bit 1 block_en
   localparam int ADDR_COMMIT      = 15;

   typedef struct packed {
      logic [3:0]  addr;
      logic [31:0] data;
   } cfg_word_t;

   // Windows are half open, start included and stop excluded
   typedef struct packed {
      logic [15:0] p1_start;
      logic [15:0] p1_stop;
      logic [15:0] p2_start;
      logic [15:0] p2_stop;
   } chan_timing_t;

   typedef struct packed {
      logic cw;
      logic block_en;
   } mode_t;

   typedef struct packed {
      logic [31:0]                          period;      // Last count of the period
      chan_timing_t [NUM_CHANNELS-1:0]      chan;
      logic [7:0]                           nut_w;
      logic [15:0]                          nut_d;       // Nutation ends this far before the end
      logic [6:0]                           att;
      logic [7:0]                           block_delay; // Blocking opens this late after p2_stop
      mode_t                                mode;
   } seq_settings_t;

   typedef struct packed {
      logic [31:0]                          count;
      logic                                 wrap;      // Last cycle of the period
      mode_t                                mode;
      logic [6:0]                           att;
      logic [31:0]                          nut_start;
      logic [31:0]                          nut_stop;
      logic [15:0]                          block_off;
      logic [15:0]                          sync_off;  // Pulsed trigger bound, channel 0 p2_stop
      logic [31:0]                          period;
      chan_timing_t [NUM_CHANNELS-1:0]      chan;      // Active windows per channel
   } timebase_t;

endpackage

// File: hdl/seq_config_rx.sv
module seq_config_rx import pulse_seq_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   input  logic          cfg_valid,      // Host only sends while holding a credit
   input  cfg_word_t     cfg_word,
   output logic          cfg_credit,     // One pulse per drained word
   input  logic          commit_ack,     // Time base took the shadow set at wrap
   output seq_settings_t shadow,
   output logic          commit_pending
);

   cfg_word_t            buf_mem [CFG_CREDITS]; // Word buffer, sized to the credit count
   logic [CFG_PTR_W-1:0] wr_ptr;
   logic [CFG_PTR_W-1:0] rd_ptr;
   logic [CFG_PTR_W:0]   fill;
   logic                 drain;
   cfg_word_t            rd_word;

   assign drain   = (fill != '0) && !commit_pending; // Frozen while a commit waits for wrap
   assign rd_word = buf_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (cfg_valid) begin
         buf_mem[wr_ptr] <= cfg_word; // Credits guarantee a free slot
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fill       <= '0;
         cfg_credit <= 1'b0;
      end else begin
         if (cfg_valid) begin
            wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two, pointers wrap freely
         end
         if (drain) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({cfg_valid, drain})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill; // Both or neither
         endcase
         cfg_credit <= drain; // Credit returns the cycle after removal
      end
   end

   // Address decode into the shadow set
   always_ff @(posedge clk) begin
      if (reset) begin
         shadow         <= '0;
         commit_pending <= 1'b0;
      end else begin
         if (commit_ack) begin
            commit_pending <= 1'b0; // Resume draining
         end
         if (drain) begin
            case (rd_word.addr)
               ADDR_PERIOD:      shadow.period      <= rd_word.data;
               ADDR_NUT_W:       shadow.nut_w       <= rd_word.data[7:0];
               ADDR_NUT_D:       shadow.nut_d       <= rd_word.data[15:0];
               ADDR_ATT:         shadow.att         <= rd_word.data[6:0];
               ADDR_BLOCK_DELAY: shadow.block_delay <= rd_word.data[7:0];
               ADDR_MODE: begin
                  shadow.mode.cw       <= rd_word.data[0];
                  shadow.mode.block_en <= rd_word.data[1];
               end
               ADDR_COMMIT:      commit_pending     <= 1'b1;
               default:          ; // Channel words decoded below, address 14 unused
            endcase
            for (int c = 0; c < NUM_CHANNELS; c++) begin
               if (rd_word.addr == 4'(ADDR_CH0_BASE + 4*c)) begin
                  shadow.chan[c].p1_start <= rd_word.data[15:0];
               end
               if (rd_word.addr == 4'(ADDR_CH0_BASE + 4*c + 1)) begin
                  shadow.chan[c].p1_stop <= rd_word.data[15:0];
               end
               if (rd_word.addr == 4'(ADDR_CH0_BASE + 4*c + 2)) begin
                  shadow.chan[c].p2_start <= rd_word.data[15:0];
               end
               if (rd_word.addr == 4'(ADDR_CH0_BASE + 4*c + 3)) begin
                  shadow.chan[c].p2_stop <= rd_word.data[15:0];
               end
            end
         end
      end
   end

endmodule

// File: hdl/seq_timebase.sv
module seq_timebase import pulse_seq_pkg::*; (
   input  logic          clk,
   input  logic          reset,
   input  seq_settings_t shadow,
   input  logic          commit_pending,
   output logic          commit_ack,
   output timebase_t     tb
);

   seq_settings_t active;    // Settings governing the current period
   logic [31:0]   count;
   logic          wrap;
   logic [31:0]   nut_start;
   logic [31:0]   nut_stop;
   logic [15:0]   block_off;
   logic [15:0]   sync_off;

   assign wrap       = (count == active.period); // Period is period+1 cycles
   assign commit_ack = wrap && commit_pending;   // Swap only on the boundary

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else if (wrap) begin
         count <= '0;
      end else begin
         count <= count + 1'b1;
      end
   end

   // Derived bounds come from the stable shadow set, not from the counter
   always_ff @(posedge clk) begin
      if (reset) begin
         active    <= '0;
         nut_start <= '0;
         nut_stop  <= '0;
         block_off <= '0;
         sync_off  <= '0;
      end else if (commit_ack) begin
         active    <= shadow;
         nut_start <= shadow.period - 32'(shadow.nut_d) - 32'(shadow.nut_w);
         nut_stop  <= shadow.period - 32'(shadow.nut_d);
         block_off <= shadow.chan[0].p2_stop + 16'(shadow.block_delay);
         sync_off  <= shadow.chan[0].p2_stop; // Equals block_off minus block_delay
      end
   end

   always_comb begin
      tb.count     = count;
      tb.wrap      = wrap;
      tb.mode      = active.mode;
      tb.att       = active.att;
      tb.nut_start = nut_start;
      tb.nut_stop  = nut_stop;
      tb.block_off = block_off;
      tb.sync_off  = sync_off;
      tb.period    = active.period;
      tb.chan      = active.chan;
   end

endmodule

// File: hdl/pulse_channel.sv
module pulse_channel import pulse_seq_pkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  chan_timing_t timing,   // This channel's active windows
   input  timebase_t    tb,
   output logic         win_on,   // Either window open, one cycle after tb
   output logic         first_on  // First window open, same timing as win_on
);

   logic in_first;
   logic in_second;

   // Half-open windows against the shared count
   assign in_first  = (tb.count >= 32'(timing.p1_start)) &&
                      (tb.count <  32'(timing.p1_stop));
   assign in_second = (tb.count >= 32'(timing.p2_start)) &&
                      (tb.count <  32'(timing.p2_stop));

   always_ff @(posedge clk) begin
      if (reset) begin
         win_on   <= 1'b0;
         first_on <= 1'b0;
      end else begin
         win_on   <= in_first | in_second;
         first_on <= in_first; // Drives the attenuator step downstream
      end
   end

endmodule

// File: hdl/pulse_output_stage.sv
module pulse_output_stage import pulse_seq_pkg::*; (
   input  logic                    clk,
   input  logic                    reset,
   input  timebase_t               tb,
   input  logic [NUM_CHANNELS-1:0] win_on,   // Already one cycle behind tb
   input  logic [NUM_CHANNELS-1:0] first_on,
   output logic                    pulse1_on,
   output logic                    pulse2_on,
   output logic                    sync_on,   // Scope trigger
   output logic                    pre_block, // Input blocking
   output logic                    inhib,     // Blocking switch
   output logic [6:0]              pre_att
);

   // Stage 1 lines up the time-base terms with the channel windows
   logic       cw_q;
   logic [6:0] att_q;
   logic       sync_cw_q;
   logic       sync_pl_q;
   logic       nut_q;
   logic       inhib_q;
   logic       guard_q;
   logic [7:0] att_sum;
   logic [6:0] att_hi;
   logic       p1_next;
   logic       p2_next;

   always_ff @(posedge clk) begin
      if (reset) begin
         cw_q      <= 1'b0;
         att_q     <= '0;
         sync_cw_q <= 1'b0;
         sync_pl_q <= 1'b0;
         nut_q     <= 1'b0;
         inhib_q   <= 1'b0;
         guard_q   <= 1'b0;
      end else begin
         cw_q      <= tb.mode.cw;
         att_q     <= tb.att;
         sync_cw_q <= tb.count < 32'(CW_SYNC_CYCLES);
         sync_pl_q <= tb.count < 32'(tb.sync_off);
         nut_q     <= (tb.count >= tb.nut_start) && (tb.count < tb.nut_stop);
         // Closed after the pulses, open again just ahead of the nutation pulse
         if (tb.count < 32'(tb.block_off)) begin
            inhib_q <= tb.mode.block_en;
         end else if ({1'b0, tb.count} + 33'(INHIBIT_LEAD) < {1'b0, tb.nut_start}) begin
            inhib_q <= 1'b0;
         end else begin
            inhib_q <= tb.mode.block_en;
         end
         guard_q   <= {1'b0, tb.count} + 33'(ATT_GUARD) >= {1'b0, tb.period}; // Wide, no underflow
      end
   end

   assign att_sum = {1'b0, att_q} + 8'(ATT_STEP);
   assign att_hi  = att_sum[7] ? 7'h7f : att_sum[6:0]; // Saturate at the code maximum
   assign p1_next = cw_q | win_on[0];                  // Switch 1 held open in CW
   assign p2_next = !cw_q & (win_on[1] | nut_q);

   // Stage 2, every output two cycles behind its count
   always_ff @(posedge clk) begin
      if (reset) begin
         pulse1_on <= 1'b0;
         pulse2_on <= 1'b0;
         sync_on   <= 1'b0;
         pre_block <= 1'b0;
         inhib     <= 1'b0;
         pre_att   <= '0;
      end else begin
         pulse1_on <= p1_next;
         pulse2_on <= p2_next;
         pre_block <= p1_next | p2_next; // Follows the pulses, always high in CW
         sync_on   <= cw_q ? sync_cw_q : sync_pl_q;
         inhib     <= !cw_q & inhib_q;
         pre_att   <= (!cw_q && ((|first_on) || guard_q)) ? att_hi : att_q;
      end
   end

endmodule

// File: hdl/pulse_seq_top.sv
module pulse_seq_top import pulse_seq_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       cfg_valid,
   input  cfg_word_t  cfg_word,
   output logic       cfg_credit,
   output logic       pulse1_on,  // Pulse switch 1
   output logic       pulse2_on,  // Pulse switch 2
   output logic       sync_on,    // Scope trigger
   output logic       pre_block,  // Input blocking
   output logic       inhib,      // Blocking switch
   output logic [6:0] pre_att     // Attenuator code
);

   seq_settings_t             shadow;
   logic                      commit_pending;
   logic                      commit_ack;
   timebase_t                 tb;
   logic [NUM_CHANNELS-1:0]   win_on;   // Indexed by channel
   logic [NUM_CHANNELS-1:0]   first_on;

   seq_config_rx u_cfg_rx (
      .clk            (clk),
      .reset          (reset),
      .cfg_valid      (cfg_valid),
      .cfg_word       (cfg_word),
      .cfg_credit     (cfg_credit),
      .commit_ack     (commit_ack),
      .shadow         (shadow),
      .commit_pending (commit_pending)
   );

   seq_timebase u_timebase (
      .clk            (clk),
      .reset          (reset),
      .shadow         (shadow),
      .commit_pending (commit_pending),
      .commit_ack     (commit_ack),
      .tb             (tb)
   );

   // Identical channels, each fed its own active windows
   for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
      pulse_channel u_chan (
         .clk      (clk),
         .reset    (reset),
         .timing   (tb.chan[g]),
         .tb       (tb),
         .win_on   (win_on[g]),
         .first_on (first_on[g])
      );
   end

   pulse_output_stage u_out (
      .clk       (clk),
      .reset     (reset),
      .tb        (tb),
      .win_on    (win_on),
      .first_on  (first_on),
      .pulse1_on (pulse1_on),
      .pulse2_on (pulse2_on),
      .sync_on   (sync_on),
      .pre_block (pre_block),
      .inhib     (inhib),
      .pre_att   (pre_att)
   );

endmodule

// File: sim/pulse_seq_asserts.sv
module pulse_seq_asserts import pulse_seq_pkg::*; (
   input logic       clk,
   input logic       reset,
   input logic       cfg_valid,
   input logic       cfg_credit,
   input timebase_t  tb,
   input logic       pulse1_on,
   input logic [6:0] pre_att
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [3:0] outstanding; // Words sent whose credit is still out

   always_ff @(posedge clk) begin
      if (reset) begin
         outstanding <= '0;
      end else begin
         outstanding <= outstanding + 4'(cfg_valid) - 4'(cfg_credit);
      end
   end

   credits_bounded: assert property (@(posedge clk) disable iff (reset)
      outstanding <= 4'(CFG_CREDITS))
      else $error("More words in flight than receiver credits");

   credit_has_word: assert property (@(posedge clk) disable iff (reset)
      cfg_credit |-> outstanding != '0)
      else $error("Credit returned with no word in the buffer");

   // Mode reaches the outputs two cycles later
   cw_switch_open: assert property (@(posedge clk) disable iff (reset)
      $past(tb.mode.cw, 2) |-> pulse1_on)
      else $error("pulse1_on dropped in CW mode");

   // Stepped code stays between att and att plus the step, so it never wraps past 127
   att_saturates: assert property (@(posedge clk) disable iff (reset)
      !$isunknown(pre_att) && pre_att >= $past(tb.att, 2) &&
      8'(pre_att) <= 8'($past(tb.att, 2)) + 8'(ATT_STEP))
      else $error("pre_att unknown or wrapped past 127");

endmodule

bind pulse_seq_top pulse_seq_asserts u_asserts (
   .clk        (clk),
   .reset      (reset),
   .cfg_valid  (cfg_valid),
   .cfg_credit (cfg_credit),
   .tb         (tb),
   .pulse1_on  (pulse1_on),
   .pre_att    (pre_att)
);

// File: sim/pulse_seq_tb.sv
module pulse_seq_tb import pulse_seq_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_ENTRIES = 64;

   typedef struct packed {
      logic       p1;
      logic       p2;
      logic       sync;
      logic       blk;
      logic       inh;
      logic [6:0] att;
   } expect_t;

   logic          clk;
   logic          reset;
   logic          cfg_valid;
   cfg_word_t     cfg_word;
   logic          cfg_credit;
   logic          pulse1_on;
   logic          pulse2_on;
   logic          sync_on;
   logic          pre_block;
   logic          inhib;
   logic [6:0]    pre_att;
   logic [39:0]   tests [MAX_ENTRIES]; // Op, address, data
   seq_settings_t model;               // Host view of the shadow set
   seq_settings_t committed;           // Snapshot at the last commit word
   seq_settings_t previous;            // Set that the last commit replaces
   int            sent;
   int            returned;
   int            checks;
   int            mismatches;
   int            other_errors;
   int            cycles;
   int            cycle_limit;
   int            commit_at;           // Cycle the last commit word was sent
   int            rise_at [$];         // Cycles of every sync_on rise
   logic          sync_last;

   pulse_seq_top dut0 (
      .clk        (clk),
      .reset      (reset),
      .cfg_valid  (cfg_valid),
      .cfg_word   (cfg_word),
      .cfg_credit (cfg_credit),
      .pulse1_on  (pulse1_on),
      .pulse2_on  (pulse2_on),
      .sync_on    (sync_on),
      .pre_block  (pre_block),
      .inhib      (inhib),
      .pre_att    (pre_att)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cfg_credit) begin
         returned++; // One credit back per pulse
      end
      if (sync_on && !sync_last) begin
         rise_at.push_back(cycles); // Period starts as seen at the outputs
      end
      sync_last = sync_on;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("Timeout after %0d cycles, the run did not finish", cycles);
         $display("Test failed");
         $finish;
      end
   end

   // Timeout budget from the data file
   function automatic int run_budget();
      int          total;
      int          j;
      logic [31:0] period;
      total  = 8;
      period = '0;
      j      = 0;
      while (j < MAX_ENTRIES && tests[j][39:36] != 4'h0) begin
         if (tests[j][39:36] == 4'h3) begin
            total += (int'(period) + 1) * 4 + 200;
         end else if (tests[j][35:32] == 4'(ADDR_PERIOD)) begin
            period = tests[j][31:0];
         end
         j++;
      end
      return total;
   endfunction

   // Host-side decode of the address map
   function automatic seq_settings_t apply_word(seq_settings_t s, cfg_word_t w);
      int a;
      a = int'(w.addr);
      if (a == ADDR_PERIOD) s.period = w.data;
      if (a == ADDR_NUT_W) s.nut_w = w.data[7:0];
      if (a == ADDR_NUT_D) s.nut_d = w.data[15:0];
      if (a == ADDR_ATT) s.att = w.data[6:0];
      if (a == ADDR_BLOCK_DELAY) s.block_delay = w.data[7:0];
      if (a == ADDR_MODE) begin
         s.mode.cw       = w.data[0];
         s.mode.block_en = w.data[1];
      end
      if (a >= ADDR_CH0_BASE && a < ADDR_CH0_BASE + 4*NUM_CHANNELS) begin
         case ((a - ADDR_CH0_BASE) % 4)
            0:       s.chan[(a - ADDR_CH0_BASE) / 4].p1_start = w.data[15:0];
            1:       s.chan[(a - ADDR_CH0_BASE) / 4].p1_stop  = w.data[15:0];
            2:       s.chan[(a - ADDR_CH0_BASE) / 4].p2_start = w.data[15:0];
            default: s.chan[(a - ADDR_CH0_BASE) / 4].p2_stop  = w.data[15:0];
         endcase
      end
      return s;
   endfunction

   function automatic logic in_window(longint c, logic [15:0] start, logic [15:0] stop);
      return c >= longint'(start) && c < longint'(stop); // Stop count excluded
   endfunction

   // Expected outputs for one count of a period
   function automatic expect_t expected_at(seq_settings_t s, longint c);
      expect_t e;
      logic    first;
      logic    nut;
      longint  nut_start;
      longint  block_off;
      int      att_up;
      nut_start = longint'(s.period) - longint'(s.nut_d) - longint'(s.nut_w);
      block_off = longint'(s.chan[0].p2_stop) + longint'(s.block_delay);
      nut       = c >= nut_start && c < longint'(s.period) - longint'(s.nut_d);
      first     = in_window(c, s.chan[0].p1_start, s.chan[0].p1_stop) ||
                  in_window(c, s.chan[1].p1_start, s.chan[1].p1_stop);
      att_up    = int'(s.att) + ATT_STEP;
      if (att_up > 127) att_up = 127;
      if (s.mode.cw) begin
         e.p1   = 1'b1;
         e.p2   = 1'b0;
         e.sync = c < CW_SYNC_CYCLES;
         e.blk  = 1'b1;
         e.inh  = 1'b0;
         e.att  = s.att;
      end else begin
         e.p1   = in_window(c, s.chan[0].p1_start, s.chan[0].p1_stop) ||
                  in_window(c, s.chan[0].p2_start, s.chan[0].p2_stop);
         e.p2   = nut || in_window(c, s.chan[1].p1_start, s.chan[1].p1_stop) ||
                  in_window(c, s.chan[1].p2_start, s.chan[1].p2_stop);
         e.sync = c < longint'(s.chan[0].p2_stop);
         e.blk  = e.p1 | e.p2;
         e.inh  = s.mode.block_en && !(c >= block_off && c + INHIBIT_LEAD < nut_start);
         e.att  = (first || c + ATT_GUARD >= longint'(s.period)) ? 7'(att_up) : s.att;
      end
      return e;
   endfunction

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         mismatches++;
         $display("Mismatch at %0t: %s expected %0b, actual %0b", $time, name, exp, act);
      end
   endtask

   task automatic check_att(input logic [6:0] exp, input logic [6:0] act);
      checks++;
      if (act !== exp) begin
         mismatches++;
         $display("Mismatch at %0t: pre_att expected %0d, actual %0d", $time, exp, act);
      end
   endtask

   // Period running when the commit arrives still ends at the old length
   task automatic check_boundary(input int unsigned old_span);
      int r;
      int actual;
      r = -1;
      foreach (rise_at[j]) begin
         if (rise_at[j] <= commit_at) begin
            r = j;
         end
      end
      if (r >= 0 && r + 1 < rise_at.size()) begin
         actual = rise_at[r+1] - rise_at[r];
         checks++;
         if (actual != int'(old_span)) begin
            mismatches++;
            $display("Mismatch at %0t: old period length expected %0d, actual %0d",
                     $time, old_span, actual);
         end
      end
   endtask

   task automatic send_word(input cfg_word_t w, input logic gaps);
      int unsigned idle;
      idle = gaps ? $urandom % 3 : 0;
      repeat (idle) @(negedge clk);
      while (sent - returned >= CFG_CREDITS) @(negedge clk); // No credit left, stall
      cfg_valid = 1'b1;
      cfg_word  = w;
      sent++;
      if (w.addr == 4'(ADDR_COMMIT)) begin
         commit_at = cycles;
      end
      @(negedge clk);
      cfg_valid = 1'b0;
   endtask

   // Lock to a sync_on rise under the new settings, then compare every cycle
   task automatic check_periods(input int nper);
      int unsigned span;
      int unsigned n;
      logic        prev;
      expect_t     e;
      span = committed.period + 1;
      while (sent != returned) @(negedge clk);
      repeat (3) @(negedge clk); // Older period starts have left the pipeline
      n    = 0;
      prev = sync_on;
      @(negedge clk);
      while (!(sync_on && !prev) && n < 4*span + 200) begin
         prev = sync_on;
         @(negedge clk);
         n++;
      end
      if (!(sync_on && !prev)) begin
         other_errors++;
         $display("sync_on never rose after the commit of period %0d", committed.period);
      end else begin
         for (int unsigned k = 0; k <= nper*span; k++) begin
            e = expected_at(committed, longint'(k % span));
            check_bit("pulse1_on", e.p1, pulse1_on);
            check_bit("pulse2_on", e.p2, pulse2_on);
            check_bit("sync_on", e.sync, sync_on);
            check_bit("pre_block", e.blk, pre_block);
            check_bit("inhib", e.inh, inhib);
            check_att(e.att, pre_att);
            @(negedge clk);
         end
         check_boundary(previous.period + 1);
      end
   endtask

   initial begin
      cfg_word_t  w;
      logic [3:0] op;
      int         i;
      clk          = 1'b0;
      reset        = 1'b1;
      cfg_valid    = 1'b0;
      cfg_word     = '0;
      model        = '0;
      committed    = '0;
      previous     = '0;
      sent         = 0;
      returned     = 0;
      checks       = 0;
      mismatches   = 0;
      other_errors = 0;
      cycles       = 0;
      cycle_limit  = 0;
      commit_at    = 0;
      sync_last    = 1'b0;
      void'($urandom(32'h4ae));
      $readmemh("sim/pulse_seq_tests.txt", tests);
      cycle_limit = run_budget();
      repeat (8) @(negedge clk);
      reset = 1'b0;
      i = 0;
      while (i < MAX_ENTRIES && tests[i][39:36] != 4'h0) begin
         op = tests[i][39:36];
         w  = tests[i][35:0];
         if (op == 4'h1 || op == 4'h2) begin
            send_word(w, op == 4'h1);
            model = apply_word(model, w);
            if (w.addr == 4'(ADDR_COMMIT)) begin
               previous  = committed;
               committed = model;
            end
         end else if (op == 4'h3) begin
            check_periods(int'(w.data));
         end else begin
            other_errors++;
            $display("Unknown op %0h in entry %0d of the data file", op, i);
         end
         i++;
      end
      if (checks == 0) begin
         other_errors++;
         $display("No checks ran, the data file gave no test cases");
      end
      $display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
               other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: pulse_seq.f
hdl/pulse_seq_pkg.sv
hdl/seq_config_rx.sv
hdl/seq_timebase.sv
hdl/pulse_channel.sv
hdl/pulse_output_stage.sv
hdl/pulse_seq_top.sv
sim/pulse_seq_asserts.sv
sim/pulse_seq_tb.sv

// File: Makefile
TOP := pulse_seq_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): pulse_seq.f $(wildcard hdl/*.sv sim/*.sv)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f pulse_seq.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		-f pulse_seq.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: sim/pulse_seq_tests.txt
// One 40-bit hex entry per line: op digit, address digit, eight data digits
// Op 1 sends after random idles, 2 sends back to back, 3 checks data periods, 0 ends
10000000C7 // Pulsed with blocking, period 199
110000000A // Channel 0 first window 10 to 20
1200000014
1300000028 // Channel 0 second window 40 to 60
140000003C
1500000019 // Channel 1 first window 25 to 30
160000001E
1700000046 // Channel 1 second window 70 to 80
1800000050
190000000C // Nutation width 12
1A0000001E // Nutation 30 before the end
1B00000028 // Attenuator 40
1C00000008 // Blocking delay 8
1D00000002 // block_en
1F00000000
3000000002
1000000095 // Blocking off and attenuator near the top, period 149
1A00000014
1B0000007D
1D00000000
1F00000000
3000000002
1000000063 // CW, period 99
1B00000020
1D00000001
1F00000000
3000000002
10000000B3 // Commit under back-pressure, period 179
1D00000002
2F00000000 // Commit, then six words with no idles
2B00000030
2900000010
2A00000019
2C0000000C
2700000050
280000005A
3000000002
1F00000000 // Burst words become active
3000000002
0000000000
